// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_cache_subsys
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FLIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
verilog/brisc_pkg.sv
verilog/cache_line.sv
verilog/cache.sv
verilog/cache_ctrl.sv
verilog/cache_subsys.sv
testbench/tb_mem.sv
testbench/tb_cache_subsys.sv

// ==== testbench/tb_cache_subsys.sv ====
`timescale 1ns/1ps

module tb_cache_subsys;
  import brisc_pkg::*;

  localparam int RANDOM_REQS = 200;
  localparam int TOTAL_REQS = 19 + RANDOM_REQS;
  // covers a slow miss with a held response
  localparam int CYCLES_PER_REQ = 20;

  logic      clk;
  logic      arst_n;
  logic      core_req_valid;
  core_req_t core_req;
  logic      core_req_ready;
  logic      core_rsp_valid;
  core_rsp_t core_rsp;
  logic      core_rsp_ready;
  logic      mem_req_valid;
  mem_req_t  mem_req;
  logic      mem_req_ready;
  logic      mem_rsp_valid;
  mem_rsp_t  mem_rsp;

  // shadow of the memory words and of the line tags
  logic [DATA_W-1:0] shadow_mem [2**ADDR_W];
  logic              shadow_valid [NUM_LINES];
  logic [TAG_W-1:0]  shadow_tag [NUM_LINES];

  // expectations for the request in flight
  string             test_name;
  mem_req_t          exp_req;
  logic              exp_hit;
  logic [DATA_W-1:0] exp_rdata;
  int                exp_reads;
  int                exp_writes;
  int                mem_reads;
  int                mem_writes;
  int                value_errors = 0;
  int                protocol_errors = 0;
  int                seed;

  cache_subsys dut_i (.*);
  tb_mem mem_i (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  function automatic logic [DATA_W-1:0] preset_word(input logic [ADDR_W-1:0] a);
    return {a ^ 16'hc35a, ~a};
  endfunction

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic transact(input logic wr, input logic [ADDR_W-1:0] a,
                          input logic [DATA_W-1:0] d, input logic [BE_W-1:0] b,
                          input int hold);
    logic [SET_W-1:0]  set;
    logic [TAG_W-1:0]  tag;
    logic              line_hit;
    logic [DATA_W-1:0] word;
    int                wait_left;
    logic              rsp_done;
    set = a[SET_W-1:0];
    tag = a[ADDR_W-1:SET_W];
    line_hit = shadow_valid[set] && (shadow_tag[set] == tag);
    word = shadow_mem[a];
    exp_req = '{write: wr, addr: a, wdata: d, be: b};
    exp_hit = line_hit;
    exp_rdata = word;
    exp_reads = (!wr && !line_hit) ? 1 : 0;
    exp_writes = wr ? 1 : 0;
    // write-through without allocation, fill on a read miss
    if (wr) begin
      for (int i = 0; i < BE_W; i++) begin
        if (b[i]) begin
          word[8*i +: 8] = d[8*i +: 8];
        end
      end
      shadow_mem[a] = word;
    end else if (!line_hit) begin
      shadow_valid[set] = 1'b1;
      shadow_tag[set] = tag;
    end
    core_req_valid <= 1'b1;
    core_req <= '{write: wr, addr: a, wdata: d, be: b};
    @(posedge clk);
    while (!core_req_ready) begin
      @(posedge clk);
    end
    core_req_valid <= 1'b0;
    wait_left = hold;
    rsp_done = 1'b0;
    core_rsp_ready <= (hold == 0) ? rand_below(2) == 1 : 1'b0;
    while (!rsp_done) begin
      @(posedge clk);
      if (core_rsp_valid && core_rsp_ready) begin
        rsp_done = 1'b1;
        core_rsp_ready <= 1'b0;
      end else if (core_rsp_valid && wait_left > 0) begin
        wait_left--;
        core_rsp_ready <= 1'b0;
      end else if (core_rsp_valid) begin
        core_rsp_ready <= 1'b1;
      end else if (hold == 0) begin
        core_rsp_ready <= rand_below(2) == 1;
      end
    end
  endtask

  // memory traffic of the current request
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_reads <= 0;
      mem_writes <= 0;
    end else if (core_req_valid && core_req_ready) begin
      mem_reads <= 0;
      mem_writes <= 0;
    end else if (mem_req_valid && mem_req_ready) begin
      if (mem_req.write) begin
        mem_writes <= mem_writes + 1;
      end else begin
        mem_reads <= mem_reads + 1;
      end
    end
  end

  check_hit : assert property (@(posedge clk) disable iff (!arst_n)
    core_rsp_valid && core_rsp_ready |-> core_rsp.hit == exp_hit)
  else begin
    value_errors++;
    $display("Error %s: hit expected %b, actual %b", test_name, $sampled(exp_hit),
             $sampled(core_rsp.hit));
  end

  check_rdata : assert property (@(posedge clk) disable iff (!arst_n)
    core_rsp_valid && core_rsp_ready && !exp_req.write |-> core_rsp.rdata == exp_rdata)
  else begin
    value_errors++;
    $display("Error %s: rdata expected %h, actual %h", test_name, $sampled(exp_rdata),
             $sampled(core_rsp.rdata));
  end

  check_mem_count : assert property (@(posedge clk) disable iff (!arst_n)
    core_rsp_valid && core_rsp_ready |-> mem_reads == exp_reads && mem_writes == exp_writes)
  else begin
    value_errors++;
    $display("Error %s: memory reads/writes expected %0d/%0d, actual %0d/%0d", test_name,
             $sampled(exp_reads), $sampled(exp_writes), $sampled(mem_reads),
             $sampled(mem_writes));
  end

  // write data and mask only matter on a write
  check_mem_req : assert property (@(posedge clk) disable iff (!arst_n)
    mem_req_valid && mem_req_ready |-> mem_req.write == exp_req.write &&
    mem_req.addr == exp_req.addr &&
    (!exp_req.write || (mem_req.wdata == exp_req.wdata && mem_req.be == exp_req.be)))
  else begin
    value_errors++;
    $display("Error %s: memory request expected %h, actual %h", test_name,
             $sampled(exp_req), $sampled(mem_req));
  end

  reset_idle : assert property (@(posedge clk)
    !arst_n |=> !core_rsp_valid && !mem_req_valid && core_req_ready)
  else begin
    protocol_errors++;
    $display("Reset left a response or a memory request pending");
  end

  rsp_held : assert property (@(posedge clk) disable iff (!arst_n)
    core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
  else begin
    protocol_errors++;
    $display("Core response dropped or changed while core_rsp_ready was low");
  end

  mem_req_held : assert property (@(posedge clk) disable iff (!arst_n)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
  else begin
    protocol_errors++;
    $display("Memory request dropped or changed while mem_req_ready was low");
  end

  busy_closed : assert property (@(posedge clk) disable iff (!arst_n)
    core_rsp_valid || mem_req_valid |-> !core_req_ready)
  else begin
    protocol_errors++;
    $display("core_req_ready was high while a request was still in progress");
  end

  initial begin
    logic              wr;
    logic [ADDR_W-1:0] a;
    seed = 32'ha7bc_6ef1;
    test_name = "reset";
    exp_req = '0;
    exp_hit = 1'b0;
    exp_rdata = '0;
    exp_reads = 0;
    exp_writes = 0;
    arst_n <= 1'b0;
    core_req_valid <= 1'b0;
    core_req <= '0;
    core_rsp_ready <= 1'b0;
    for (int i = 0; i < 2**ADDR_W; i++) begin
      shadow_mem[i] = preset_word(ADDR_W'(i));
    end
    for (int s = 0; s < NUM_LINES; s++) begin
      shadow_valid[s] = 1'b0;
      shadow_tag[s] = '0;
    end
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    transact(1'b0, 16'h0010, '0, '0, 0);
    transact(1'b0, 16'h0123, '0, '0, 0);
    test_name = "miss_then_hit";
    transact(1'b0, 16'h0010, '0, '0, 0);
    transact(1'b0, 16'h0123, '0, '0, 0);
    // set 5 with tags 3 and 4
    test_name = "conflict";
    repeat (3) begin
      transact(1'b0, 16'h0035, '0, '0, 0);
      transact(1'b0, 16'h0045, '0, '0, 0);
    end
    test_name = "write_through";
    transact(1'b1, 16'h0010, 32'hdead_beef, 4'b0101, 0);
    transact(1'b0, 16'h0010, '0, '0, 0);
    transact(1'b1, 16'h0207, 32'h1234_5678, 4'b1100, 0);
    transact(1'b0, 16'h0207, '0, '0, 0);
    transact(1'b0, 16'h0207, '0, '0, 0);
    test_name = "back_pressure";
    transact(1'b0, 16'h0099, '0, '0, 5);
    transact(1'b1, 16'h0099, 32'h0bad_f00d, 4'b1111, 5);
    transact(1'b0, 16'h0099, '0, '0, 5);
    transact(1'b1, 16'h00a1, 32'h5555_aaaa, 4'b0011, 6);
    test_name = "random_mix";
    repeat (RANDOM_REQS) begin
      wr = rand_below(3) == 0;
      a = ADDR_W'(rand_below(64));
      transact(wr, a, DATA_W'($random(seed)), BE_W'(rand_below(16)), rand_below(4));
    end
    repeat (2) @(posedge clk);
    $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    repeat (TOTAL_REQS * CYCLES_PER_REQ) @(posedge clk);
    $display("Timeout: the requests did not finish in %0d cycles, the DUT seems hung",
             TOTAL_REQS * CYCLES_PER_REQ);
    $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== testbench/tb_mem.sv ====
`timescale 1ns/1ps

module tb_mem (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                mem_req_valid,
  input  brisc_pkg::mem_req_t mem_req,
  output logic                mem_req_ready,
  output logic                mem_rsp_valid,
  output brisc_pkg::mem_rsp_t mem_rsp
);
  import brisc_pkg::*;

  logic [DATA_W-1:0] words [2**ADDR_W];
  logic [ADDR_W-1:0] rd_addr;
  logic              pending;
  int                countdown;
  int                seed;

  // every address bit shows up in the preset word
  function automatic logic [DATA_W-1:0] preset_word(input logic [ADDR_W-1:0] a);
    return {a ^ 16'hc35a, ~a};
  endfunction

  initial begin
    seed = 32'ha7bc_6ef1;
    for (int i = 0; i < 2**ADDR_W; i++) begin
      words[i] = preset_word(ADDR_W'(i));
    end
    pending = 1'b0;
    countdown = 0;
    rd_addr = '0;
    mem_req_ready <= 1'b0;
    mem_rsp_valid <= 1'b0;
    mem_rsp <= '0;
    forever begin
      @(posedge clk);
      mem_rsp_valid <= 1'b0;
      if (!arst_n) begin
        pending = 1'b0;
      end else if (mem_req_valid && mem_req_ready) begin
        if (mem_req.write) begin
          for (int b = 0; b < BE_W; b++) begin
            if (mem_req.be[b]) begin
              words[mem_req.addr][8*b +: 8] = mem_req.wdata[8*b +: 8];
            end
          end
        end else begin
          pending = 1'b1;
          rd_addr = mem_req.addr;
          // read latency of 1 to 8 cycles
          countdown = $random(seed) & 7;
        end
      end
      if (pending && countdown == 0) begin
        mem_rsp_valid <= 1'b1;
        mem_rsp <= '{rdata: words[rd_addr]};
        pending = 1'b0;
      end else if (pending) begin
        countdown--;
      end
      // random acceptance, closed while a read is outstanding
      mem_req_ready <= arst_n && !pending && (($random(seed) & 3) != 0);
    end
  end

endmodule

// ==== verilog/brisc_pkg.sv ====
package brisc_pkg;

  // word and address geometry
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned SET_W = 4;
  localparam int unsigned NUM_LINES = 2 ** SET_W;
  localparam int unsigned TAG_W = ADDR_W - SET_W;
  localparam int unsigned BE_W = DATA_W / 8;

  // core side request, one word per transfer
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } core_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              hit;
  } core_rsp_t;

  // backing memory request, same layout as the core request
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  // set index sits in the low address bits
  function automatic logic [SET_W-1:0] addr_set(input logic [ADDR_W-1:0] addr);
    return addr[SET_W-1:0];
  endfunction

  // tag is everything above the set index
  function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] addr);
    return addr[ADDR_W-1:SET_W];
  endfunction

endpackage

// ==== verilog/cache.sv ====
`timescale 1ns/1ps

module cache (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic [brisc_pkg::ADDR_W-1:0] addr,
  input  logic                         write,
  input  logic                         fill,
  input  logic [brisc_pkg::BE_W-1:0]   be,
  input  logic [brisc_pkg::DATA_W-1:0] data_in,
  output logic                         hit,
  output logic [brisc_pkg::DATA_W-1:0] data_out
);
  import brisc_pkg::*;

  logic [SET_W-1:0] set;
  logic [TAG_W-1:0] tag;

  // per line enables and outputs
  logic              write_lines [NUM_LINES];
  logic              fill_lines  [NUM_LINES];
  logic              valid_lines [NUM_LINES];
  logic [TAG_W-1:0]  tag_lines   [NUM_LINES];
  logic [DATA_W-1:0] data_lines  [NUM_LINES];

  assign set = addr_set(addr);
  assign tag = addr_tag(addr);

  // only the addressed line sees the strobes
  always_comb begin
    for (int i = 0; i < NUM_LINES; i++) begin
      write_lines[i] = write && (set == SET_W'(i));
      fill_lines[i]  = fill && (set == SET_W'(i));
    end
  end

  genvar i;
  generate
    for (i = 0; i < NUM_LINES; i++) begin : g_line
      cache_line line_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .write     (write_lines[i]),
        .fill      (fill_lines[i]),
        .be        (be),
        .tag_in    (tag),
        .data_in   (data_in),
        .valid_out (valid_lines[i]),
        .tag_out   (tag_lines[i]),
        .data_out  (data_lines[i])
      );
    end
  endgenerate

  // hit is a valid line holding the same tag
  assign hit      = valid_lines[set] && (tag_lines[set] == tag);
  assign data_out = data_lines[set];

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                         clk,
  input  logic                         arst_n,

  // core request channel
  input  logic                         core_req_valid,
  input  brisc_pkg::core_req_t         core_req,
  output logic                         core_req_ready,

  // core response channel
  output logic                         core_rsp_valid,
  output brisc_pkg::core_rsp_t         core_rsp,
  input  logic                         core_rsp_ready,

  // backing memory channels
  output logic                         mem_req_valid,
  output brisc_pkg::mem_req_t          mem_req,
  input  logic                         mem_req_ready,
  input  logic                         mem_rsp_valid,
  input  brisc_pkg::mem_rsp_t          mem_rsp,

  // lookup side
  output logic [brisc_pkg::ADDR_W-1:0] addr,
  output logic                         write,
  output logic                         fill,
  output logic [brisc_pkg::BE_W-1:0]   be,
  output logic [brisc_pkg::DATA_W-1:0] wdata,
  input  logic                         hit,
  input  logic [brisc_pkg::DATA_W-1:0] line_data
);
  import brisc_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_mem_issue,
    st_mem_wait,
    st_respond
  } state_t;

  state_t state_q;
  state_t state_d;

  // request held for the whole transaction
  core_req_t         req_q;
  logic              hit_q;
  logic [DATA_W-1:0] rsp_data_q;

  logic req_xfer;
  logic mem_req_xfer;
  logic rsp_xfer;

  // handshakes
  assign core_req_ready = (state_q == st_idle);
  assign mem_req_valid  = (state_q == st_mem_issue);
  assign core_rsp_valid = (state_q == st_respond);

  assign req_xfer     = core_req_valid && core_req_ready;
  assign mem_req_xfer = mem_req_valid && mem_req_ready;
  assign rsp_xfer     = core_rsp_valid && core_rsp_ready;

  // lookup follows the incoming request while idle, the held one after
  always_comb begin
    if (state_q == st_idle) begin
      addr = core_req.addr;
      be   = core_req.be;
    end else begin
      addr = req_q.addr;
      be   = req_q.be;
    end
  end

  // write hit updates the line on the acceptance edge
  assign write = req_xfer && core_req.write && hit;

  // fill on the edge the read data shows up
  assign fill  = (state_q == st_mem_wait) && mem_rsp_valid;
  assign wdata = fill ? mem_rsp.rdata : core_req.wdata;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req_xfer) begin
          if (!core_req.write && hit) begin
            state_d = st_respond;
          end else begin
            state_d = st_mem_issue;
          end
        end
      end
      st_mem_issue: begin
        if (mem_req_xfer) begin
          state_d = req_q.write ? st_respond : st_mem_wait;
        end
      end
      st_mem_wait: begin
        if (mem_rsp_valid) begin
          state_d = st_respond;
        end
      end
      st_respond: begin
        if (rsp_xfer) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (req_xfer) begin
      req_q      <= core_req;
      hit_q      <= hit;
      // old line data, also what a write returns
      rsp_data_q <= line_data;
    end else if (fill) begin
      rsp_data_q <= mem_rsp.rdata;
    end
  end

  assign mem_req = '{
    write: req_q.write,
    addr:  req_q.addr,
    wdata: req_q.wdata,
    be:    req_q.be
  };

  assign core_rsp = '{rdata: rsp_data_q, hit: hit_q};

  // held payloads under back-pressure
  a_core_rsp_stable : assert property (
    @(posedge clk) disable iff (!arst_n)
    core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp)
  );

  a_mem_req_stable : assert property (
    @(posedge clk) disable iff (!arst_n)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req)
  );

  // only one read can be outstanding
  a_mem_rsp_in_wait : assert property (
    @(posedge clk) disable iff (!arst_n)
    mem_rsp_valid |-> state_q == st_mem_wait
  );

  // port stays closed until the response is taken
  a_one_request : assert property (
    @(posedge clk) disable iff (!arst_n)
    !core_req_ready && !rsp_xfer |=> !core_req_ready
  );

endmodule

// ==== verilog/cache_line.sv ====
`timescale 1ns/1ps

module cache_line (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         write,
  input  logic                         fill,
  input  logic [brisc_pkg::BE_W-1:0]   be,
  input  logic [brisc_pkg::TAG_W-1:0]  tag_in,
  input  logic [brisc_pkg::DATA_W-1:0] data_in,
  output logic                         valid_out,
  output logic [brisc_pkg::TAG_W-1:0]  tag_out,
  output logic [brisc_pkg::DATA_W-1:0] data_out
);
  import brisc_pkg::*;

  logic              valid_q;
  logic [TAG_W-1:0]  tag_q;
  logic [DATA_W-1:0] data_q;

  // valid is the only control bit of a line
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (fill) begin
      valid_q <= 1'b1;
    end
  end

  // fill takes the full word, write only the enabled bytes
  always_ff @(posedge clk) begin
    if (fill) begin
      tag_q <= tag_in;
    end
    for (int b = 0; b < BE_W; b++) begin
      if (fill || (write && be[b])) begin
        data_q[8*b +: 8] <= data_in[8*b +: 8];
      end
    end
  end

  assign valid_out = valid_q;
  assign tag_out   = tag_q;
  assign data_out  = data_q;

  // controller never fills and writes the same cycle
  a_no_write_and_fill : assert property (
    @(posedge clk) disable iff (!arst_n) !(write && fill)
  );

endmodule

// ==== verilog/cache_subsys.sv ====
`timescale 1ns/1ps

module cache_subsys (
  input  logic                 clk,
  input  logic                 arst_n,

  input  logic                 core_req_valid,
  input  brisc_pkg::core_req_t core_req,
  output logic                 core_req_ready,

  output logic                 core_rsp_valid,
  output brisc_pkg::core_rsp_t core_rsp,
  input  logic                 core_rsp_ready,

  output logic                 mem_req_valid,
  output brisc_pkg::mem_req_t  mem_req,
  input  logic                 mem_req_ready,

  input  logic                 mem_rsp_valid,
  input  brisc_pkg::mem_rsp_t  mem_rsp
);
  import brisc_pkg::*;

  // controller to lookup
  logic [ADDR_W-1:0] addr;
  logic              write;
  logic              fill;
  logic [BE_W-1:0]   be;
  logic [DATA_W-1:0] wdata;

  // lookup results
  logic              hit;
  logic [DATA_W-1:0] line_data;

  cache_ctrl ctrl_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .core_req_valid (core_req_valid),
    .core_req       (core_req),
    .core_req_ready (core_req_ready),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp       (core_rsp),
    .core_rsp_ready (core_rsp_ready),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_req_ready  (mem_req_ready),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp        (mem_rsp),
    .addr           (addr),
    .write          (write),
    .fill           (fill),
    .be             (be),
    .wdata          (wdata),
    .hit            (hit),
    .line_data      (line_data)
  );

  cache cache_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .addr     (addr),
    .write    (write),
    .fill     (fill),
    .be       (be),
    .data_in  (wdata),
    .hit      (hit),
    .data_out (line_data)
  );

endmodule
